//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_stage \
  -f verilog.f -o tb_mem_stage > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1

//--- sim/mem_stage_sva.sv
`timescale 1ns/1ps

module mem_stage_sva (
  input logic               clk_i,
  input logic               rst_i,
  input logic               stall_i,
  input logic               entry_trap_i,
  input lsu_pkg::dmem_req_t req_i,
  input lsu_pkg::mem_wb_t   wb_i
);

  // request valid is a one cycle pulse
  req_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |=> !req_i.valid)
    else $error("memory request valid held for more than one cycle");

  // a stalled edge loads a bubble into the output register
  stall_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> !wb_i.valid)
    else $error("writeback valid after a stalled cycle");

  trap_no_req: assert property (@(posedge clk_i) disable iff (rst_i)
    entry_trap_i |-> !req_i.valid)
    else $error("memory request issued for a trapped entry");

endmodule

bind mem_stage mem_stage_sva sva_inst (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .stall_i      (stall_o),
  .entry_trap_i (entry_trap),
  .req_i        (mem_req_o),
  .wb_i         (wb_o)
);

//--- sim/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
  import lsu_pkg::*;

  localparam int TIMEOUT = 50;

  logic      clk_i;
  logic      rst_i;
  ex_mem_t   ex_i;
  word_t     mem_rdata_i;
  logic      mem_done_i;
  logic      stall_o;
  dmem_req_t mem_req_o;
  mem_wb_t   wb_o;

  // responder memory and the testbench's own copy of what it should hold
  word_t     mem_model [64];
  word_t     ref_mem [64];
  mem_wb_t   exp_wb [$];
  dmem_req_t exp_req [$];
  integer    seed = 13676;
  int        errors = 0;
  int        checks = 0;
  word_t     pc_cnt = 32'h0000_1000;
  string     cur_test = "reset";

  mem_stage UUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ex_i        (ex_i),
    .mem_rdata_i (mem_rdata_i),
    .mem_done_i  (mem_done_i),
    .stall_o     (stall_o),
    .mem_req_o   (mem_req_o),
    .wb_o        (wb_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ************************************************************************
  // compare tasks and reference rules
  // ************************************************************************

  task automatic check_wb(input string name, input mem_wb_t exp, input mem_wb_t act);
    logic bad;
    bad = (act.valid !== exp.valid) || (act.trap_valid !== exp.trap_valid) ||
          (act.rd_addr !== exp.rd_addr);
    // data only matters without a trap, cause and pc only with one
    if (exp.trap_valid)
      bad = bad || (act.trap_mcause !== exp.trap_mcause) || (act.trap_pc !== exp.trap_pc);
    else
      bad = bad || (act.rd_wdata !== exp.rd_wdata);
    checks++;
    if (bad)
    begin
      errors++;
      $display("ERR %s: wb expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_req(input string name, input dmem_req_t exp, input dmem_req_t act);
    logic bad;
    bad = (act.valid !== exp.valid) || (act.wen !== exp.wen) ||
          (act.addr !== exp.addr) || (act.strb !== exp.strb);
    if (exp.wen)
      bad = bad || (act.wdata !== exp.wdata);
    checks++;
    if (bad)
    begin
      errors++;
      $display("ERR %s: request expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic int size_of(input mem_op_t op);
    case (op)
      MEM_LB, MEM_LBU, MEM_SB: return 1;
      MEM_LH, MEM_LHU, MEM_SH: return 2;
      MEM_LW, MEM_SW:          return 4;
      default:                 return 0;
    endcase
  endfunction

  function automatic strb_t lane_strb(input int size, input byte_off_t off);
    case (size)
      1:       return 4'b0001 << off;
      2:       return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t load_value(input mem_op_t op, input word_t line,
                                       input byte_off_t off);
    logic [7:0]  b;
    logic [15:0] h;
    b = line[8*off +: 8];
    h = line[16*off[1] +: 16];
    case (op)
      MEM_LB:  return {{24{b[7]}}, b};
      MEM_LBU: return {24'd0, b};
      MEM_LH:  return {{16{h[15]}}, h};
      MEM_LHU: return {16'd0, h};
      default: return line;
    endcase
  endfunction

  // ************************************************************************
  // stimulus
  // ************************************************************************

  // hold the entry until an edge with stall low takes it
  task automatic issue(input ex_mem_t e);
    int n;
    ex_i = e;
    n = 0;
    @(negedge clk_i);
    while (stall_o && n < TIMEOUT)
    begin
      n++;
      @(negedge clk_i);
    end
    if (stall_o)
    begin
      errors++;
      $display("%s: timeout, stall never released", cur_test);
    end
    @(posedge clk_i);
    #1;
    ex_i = '0;
  endtask

  task automatic do_op(input mem_op_t op, input word_t addr, input word_t sdata,
                       input logic link, input logic trap, input word_t cause);
    ex_mem_t   e;
    mem_wb_t   w;
    dmem_req_t r;
    int        size;
    logic      store;
    logic      mis;
    word_t     wd;
    byte_off_t off;
    size   = size_of(op);
    store  = op inside {MEM_SB, MEM_SH, MEM_SW};
    off    = addr[1:0];
    mis    = (size == 2 && off[0]) || (size == 4 && off != 2'b00);
    pc_cnt = pc_cnt + 4;
    e             = '0;
    e.valid       = 1'b1;
    e.pc          = pc_cnt;
    e.pc_plus_4   = pc_cnt + 4;
    e.rd_addr     = {pc_cnt[5:2], 1'b1};
    e.mem_op      = op;
    e.is_link     = link;
    e.alu_result  = addr;
    e.store_wdata = sdata;
    e.trap_valid  = trap;
    e.trap_mcause = cause;
    w         = '0;
    w.valid   = 1'b1;
    w.rd_addr = e.rd_addr;
    if (trap || mis)
    begin
      w.trap_valid  = 1'b1;
      w.trap_mcause = trap ? cause : (store ? TRAP_STORE_MISALIGNED : TRAP_LOAD_MISALIGNED);
      w.trap_pc     = pc_cnt;
      w.rd_addr     = '0;
    end
    if (link)
      w.rd_wdata = pc_cnt + 4;
    else if (size != 0 && !store)
      w.rd_wdata = load_value(op, ref_mem[addr[7:2]], off);
    else
      w.rd_wdata = addr;
    // only a legal access reaches memory
    if (size != 0 && !trap && !mis)
    begin
      wd = (size == 1) ? {4{sdata[7:0]}} : (size == 2) ? {2{sdata[15:0]}} : sdata;
      r  = '{valid: 1'b1, wen: store, addr: addr, wdata: wd, strb: lane_strb(size, off)};
      for (int k = 0; k < 4; k++)
        if (store && r.strb[k])
          ref_mem[addr[7:2]][8*k +: 8] = wd[8*k +: 8];
      exp_req.push_back(r);
    end
    exp_wb.push_back(w);
    issue(e);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_wb.size() != 0 || exp_req.size() != 0) && n < TIMEOUT)
    begin
      n++;
      @(negedge clk_i);
    end
    if (exp_wb.size() != 0 || exp_req.size() != 0)
    begin
      errors++;
      $display("%s: timeout, %0d results and %0d requests never arrived",
               cur_test, exp_wb.size(), exp_req.size());
      exp_wb.delete();
      exp_req.delete();
    end
    @(posedge clk_i);
    #1;
  endtask

  // ************************************************************************
  // memory responder and writeback monitor
  // ************************************************************************

  initial
  begin
    dmem_req_t got;
    int        lat;
    for (int i = 0; i < 64; i++)
    begin
      mem_model[i] = 32'h9E37_79B9 * (i + 1);
      ref_mem[i]   = mem_model[i];
    end
    forever
    begin
      @(negedge clk_i);
      if (!rst_i && mem_req_o.valid)
      begin
        got = mem_req_o;
        if (exp_req.size() == 0)
        begin
          errors++;
          $display("%s: memory request to %h that should not exist", cur_test, got.addr);
        end
        else
          check_req(cur_test, exp_req.pop_front(), got);
        lat = 1 + ($random(seed) & 3);
        repeat (lat) @(posedge clk_i);
        #1;
        mem_rdata_i = mem_model[got.addr[7:2]];
        for (int k = 0; k < 4; k++)
          if (got.wen && got.strb[k])
            mem_model[got.addr[7:2]][8*k +: 8] = got.wdata[8*k +: 8];
        mem_done_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_done_i = 1'b0;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(negedge clk_i);
      if (!rst_i && wb_o.valid)
      begin
        if (exp_wb.size() == 0)
        begin
          errors++;
          $display("%s: writeback without a matching instruction", cur_test);
        end
        else
          check_wb(cur_test, exp_wb.pop_front(), wb_o);
      end
    end
  end

  // ************************************************************************
  // directed tests
  // ************************************************************************

  task automatic test_passthrough();
    ex_mem_t e;
    cur_test = "passthrough";
    do_op(MEM_NONE, 32'h1234_5678, '0, 1'b0, 1'b0, '0);
    do_op(MEM_NONE, 32'h0000_0ABC, '0, 1'b1, 1'b0, '0);
    // invalid entry, even with a store op, must stay silent
    e            = '0;
    e.mem_op     = MEM_SW;
    e.alu_result = 32'h0000_0010;
    e.rd_addr    = 5'd7;
    issue(e);
    do_op(MEM_NONE, 32'hCAFE_0001, '0, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic test_stores();
    cur_test = "stores";
    for (int off = 0; off < 4; off++)
      do_op(MEM_SB, 32'h40 + off, 32'hA1B2_C3D0 + off, 1'b0, 1'b0, '0);
    do_op(MEM_SH, 32'h44, 32'h0BAD_F00D, 1'b0, 1'b0, '0);
    do_op(MEM_SH, 32'h46, 32'h0000_8E71, 1'b0, 1'b0, '0);
    do_op(MEM_SW, 32'h48, 32'h7654_3210, 1'b0, 1'b0, '0);
    // read the words back through the stage
    do_op(MEM_LW, 32'h40, '0, 1'b0, 1'b0, '0);
    do_op(MEM_LW, 32'h44, '0, 1'b0, 1'b0, '0);
    do_op(MEM_LW, 32'h48, '0, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic test_loads();
    cur_test = "loads";
    for (int off = 0; off < 4; off++)
    begin
      do_op(MEM_LB, 32'h80 + off, '0, 1'b0, 1'b0, '0);
      do_op(MEM_LBU, 32'h84 + off, '0, 1'b0, 1'b0, '0);
      if (off % 2 == 0)
      begin
        do_op(MEM_LH, 32'h88 + off, '0, 1'b0, 1'b0, '0);
        do_op(MEM_LHU, 32'h8C + off, '0, 1'b0, 1'b0, '0);
      end
    end
    do_op(MEM_LW, 32'h90, '0, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic test_misaligned();
    cur_test = "misaligned";
    do_op(MEM_LH, 32'h21, '0, 1'b0, 1'b0, '0);
    do_op(MEM_LHU, 32'h23, '0, 1'b0, 1'b0, '0);
    do_op(MEM_LW, 32'h22, '0, 1'b0, 1'b0, '0);
    do_op(MEM_SH, 32'h25, 32'h1111_2222, 1'b0, 1'b0, '0);
    do_op(MEM_SW, 32'h27, 32'h3333_4444, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic test_incoming_trap();
    cur_test = "incoming_trap";
    do_op(MEM_SW, 32'h31, 32'h5555_6666, 1'b0, 1'b1, 32'd2);
    do_op(MEM_LW, 32'h30, '0, 1'b0, 1'b1, 32'd1);
    do_op(MEM_SB, 32'h33, 32'h0000_00AA, 1'b0, 1'b1, 32'd5);
    drain();
  endtask

  task automatic test_backpressure();
    mem_op_t op;
    word_t   a;
    int      sel;
    cur_test = "backpressure";
    for (int i = 0; i < 40; i++)
    begin
      sel = int'($unsigned($random(seed)) % 9);
      case (sel)
        0:       op = MEM_NONE;
        1:       op = MEM_LB;
        2:       op = MEM_LH;
        3:       op = MEM_LW;
        4:       op = MEM_LBU;
        5:       op = MEM_LHU;
        6:       op = MEM_SB;
        7:       op = MEM_SH;
        default: op = MEM_SW;
      endcase
      a = $random(seed) & 32'hFF;
      if (size_of(op) == 2)
        a[0] = 1'b0;
      if (size_of(op) == 4)
        a[1:0] = 2'b00;
      do_op(op, a, $random(seed), 1'b0, 1'b0, '0);
    end
    drain();
  endtask

  initial
  begin
    rst_i       = 1'b1;
    ex_i        = '0;
    mem_rdata_i = '0;
    mem_done_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    if (stall_o || mem_req_o.valid || wb_o.valid || wb_o.trap_valid)
    begin
      errors++;
      $display("outputs are not idle after reset");
    end
    @(posedge clk_i);
    #1;
    test_passthrough();
    test_stores();
    test_loads();
    test_misaligned();
    test_incoming_trap();
    test_backpressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- src/load_align.sv
`timescale 1ns/1ps

module load_align (
  input  lsu_pkg::mem_op_t   mem_op_i,
  input  lsu_pkg::byte_off_t byte_off_i,
  input  lsu_pkg::word_t     rdata_i,
  output lsu_pkg::word_t     rdata_o,
  output lsu_pkg::strb_t     rstrb_o,
  output logic               misaligned_o
);
  import lsu_pkg::*;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  // addressed byte and halfword of the returned word
  always_comb
  begin
    lane_byte = rdata_i[{byte_off_i, 3'b000} +: 8];
    lane_half = byte_off_i[1] ? rdata_i[31:16] : rdata_i[15:0];
  end

  always_comb
  begin
    rdata_o      = '0;
    rstrb_o      = '0;
    misaligned_o = 1'b0;
    case (mem_op_i)
      MEM_LB:
      begin
        rdata_o = {{(XLEN-8){lane_byte[7]}}, lane_byte};
        rstrb_o = strb_t'(1) << byte_off_i;
      end
      MEM_LBU:
      begin
        rdata_o = {{(XLEN-8){1'b0}}, lane_byte};
        rstrb_o = strb_t'(1) << byte_off_i;
      end
      MEM_LH:
      begin
        rdata_o      = {{(XLEN-16){lane_half[15]}}, lane_half};
        rstrb_o      = byte_off_i[1] ? 4'b1100 : 4'b0011;
        // halfword must sit on an even address
        misaligned_o = byte_off_i[0];
      end
      MEM_LHU:
      begin
        rdata_o      = {{(XLEN-16){1'b0}}, lane_half};
        rstrb_o      = byte_off_i[1] ? 4'b1100 : 4'b0011;
        misaligned_o = byte_off_i[0];
      end
      MEM_LW:
      begin
        rdata_o      = rdata_i;
        rstrb_o      = 4'b1111;
        misaligned_o = |byte_off_i;
      end
      default:
      begin
        // stores and non-memory ops touch no read lanes
        rdata_o      = '0;
        rstrb_o      = '0;
        misaligned_o = 1'b0;
      end
    endcase
  end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

  // ************************************************************************
  // widths and trap codes
  // ************************************************************************

  localparam int XLEN       = 32;
  localparam int STRB_W     = XLEN / 8;
  localparam int REG_ADDR_W = 5;
  localparam int MEM_OP_W   = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [1:0]            byte_off_t;

  // mcause values for misaligned data accesses
  localparam word_t TRAP_LOAD_MISALIGNED  = 32'd4;
  localparam word_t TRAP_STORE_MISALIGNED = 32'd6;

  // ************************************************************************
  // enums
  // ************************************************************************

  // bit 4 marks a memory op, bit 3 a store
  // bit 2 unsigned load, bits 1:0 access size
  typedef enum logic [MEM_OP_W-1:0] {
    MEM_NONE = 5'b00000,
    MEM_LB   = 5'b10000,
    MEM_LH   = 5'b10001,
    MEM_LW   = 5'b10010,
    MEM_LBU  = 5'b10100,
    MEM_LHU  = 5'b10101,
    MEM_SB   = 5'b11000,
    MEM_SH   = 5'b11001,
    MEM_SW   = 5'b11010
  } mem_op_t;

  typedef enum logic {
    ACC_IDLE,
    ACC_WAIT
  } access_state_t;

  // ************************************************************************
  // stage structs
  // ************************************************************************

  // executed instruction entering the memory stage
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     pc_plus_4;
    reg_addr_t rd_addr;
    mem_op_t   mem_op;
    // jal or jalr
    logic      is_link;
    // also the memory address
    word_t     alu_result;
    word_t     store_wdata;
    logic      trap_valid;
    word_t     trap_mcause;
  } ex_mem_t;

  // result toward writeback
  typedef struct packed {
    logic      valid;
    reg_addr_t rd_addr;
    word_t     rd_wdata;
    logic      trap_valid;
    word_t     trap_mcause;
    word_t     trap_pc;
  } mem_wb_t;

  // data memory request, held stable until done
  typedef struct packed {
    logic  valid;
    logic  wen;
    word_t addr;
    word_t wdata;
    strb_t strb;
  } dmem_req_t;

endpackage

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  lsu_pkg::ex_mem_t   ex_i,
  input  lsu_pkg::word_t     mem_rdata_i,
  input  logic               mem_done_i,
  output logic               stall_o,
  output lsu_pkg::dmem_req_t mem_req_o,
  output lsu_pkg::mem_wb_t   wb_o
);
  import lsu_pkg::*;

  ex_mem_t       ex_q;
  mem_wb_t       wb_d;
  mem_wb_t       wb_q;
  access_state_t state_q;
  access_state_t state_d;

  mem_op_t   op;
  byte_off_t byte_off;
  logic      entry_trap;
  logic      is_load;
  logic      is_store;
  logic      mem_access;

  word_t load_data;
  strb_t rstrb;
  logic  load_misaligned;
  word_t store_data;
  strb_t wstrb;
  logic  store_misaligned;

  // ************************************************************************
  // stage register
  // ************************************************************************

  // holds while an access waits for done
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ex_q.valid      <= 1'b0;
      ex_q.trap_valid <= 1'b0;
    end
    else if (!stall_o)
    begin
      ex_q <= ex_i;
    end
  end

  // invalid or already trapped entries must not reach memory
  always_comb
  begin
    entry_trap = ex_q.valid & ex_q.trap_valid;
    if (!ex_q.valid || ex_q.trap_valid)
    begin
      op = MEM_NONE;
    end
    else
    begin
      op = ex_q.mem_op;
    end
    byte_off = ex_q.alu_result[1:0];
    is_load  = op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    is_store = op inside {MEM_SB, MEM_SH, MEM_SW};
  end

  load_align load_align_inst (
    .mem_op_i     (op),
    .byte_off_i   (byte_off),
    .rdata_i      (mem_rdata_i),
    .rdata_o      (load_data),
    .rstrb_o      (rstrb),
    .misaligned_o (load_misaligned)
  );

  store_align store_align_inst (
    .mem_op_i     (op),
    .byte_off_i   (byte_off),
    .wdata_i      (ex_q.store_wdata),
    .wdata_o      (store_data),
    .wstrb_o      (wstrb),
    .misaligned_o (store_misaligned)
  );

  // ************************************************************************
  // memory request
  // ************************************************************************

  // misaligned accesses trap without a request
  assign mem_access = (is_load | is_store) & ~load_misaligned & ~store_misaligned;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ACC_IDLE:
      begin
        if (mem_access)
        begin
          state_d = ACC_WAIT;
        end
      end
      ACC_WAIT:
      begin
        if (mem_done_i)
        begin
          state_d = ACC_IDLE;
        end
      end
      default:
      begin
        state_d = ACC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= ACC_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // valid pulses once on entry; the rest follows the held stage register
  always_comb
  begin
    mem_req_o.valid = (state_q == ACC_IDLE) & mem_access;
    mem_req_o.wen   = is_store;
    mem_req_o.addr  = ex_q.alu_result;
    mem_req_o.wdata = store_data;
    mem_req_o.strb  = is_store ? wstrb : rstrb;
  end

  // released in the done cycle so the next entry loads on the retiring edge
  assign stall_o = mem_access & ~((state_q == ACC_WAIT) & mem_done_i);

  // ************************************************************************
  // trap priority and writeback select
  // ************************************************************************

  always_comb
  begin
    wb_d.valid       = ex_q.valid;
    wb_d.trap_valid  = 1'b0;
    wb_d.trap_mcause = '0;
    wb_d.trap_pc     = '0;
    if (entry_trap)
    begin
      // earlier stage wins
      wb_d.trap_valid  = 1'b1;
      wb_d.trap_mcause = ex_q.trap_mcause;
      wb_d.trap_pc     = ex_q.pc;
    end
    else if (store_misaligned)
    begin
      wb_d.trap_valid  = 1'b1;
      wb_d.trap_mcause = TRAP_STORE_MISALIGNED;
      wb_d.trap_pc     = ex_q.pc;
    end
    else if (load_misaligned)
    begin
      wb_d.trap_valid  = 1'b1;
      wb_d.trap_mcause = TRAP_LOAD_MISALIGNED;
      wb_d.trap_pc     = ex_q.pc;
    end

    if (ex_q.is_link)
    begin
      wb_d.rd_wdata = ex_q.pc_plus_4;
    end
    else if (is_load)
    begin
      wb_d.rd_wdata = load_data;
    end
    else
    begin
      wb_d.rd_wdata = ex_q.alu_result;
    end

    // no register write for a trap or a bubble
    if (!ex_q.valid || wb_d.trap_valid)
    begin
      wb_d.rd_addr = '0;
    end
    else
    begin
      wb_d.rd_addr = ex_q.rd_addr;
    end
  end

  // ************************************************************************
  // output register
  // ************************************************************************

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wb_q.valid      <= 1'b0;
      wb_q.trap_valid <= 1'b0;
    end
    else if (stall_o)
    begin
      // bubble while the access is outstanding
      wb_q.valid      <= 1'b0;
      wb_q.trap_valid <= 1'b0;
    end
    else
    begin
      wb_q <= wb_d;
    end
  end

  assign wb_o = wb_q;

endmodule

//--- src/store_align.sv
`timescale 1ns/1ps

module store_align (
  input  lsu_pkg::mem_op_t   mem_op_i,
  input  lsu_pkg::byte_off_t byte_off_i,
  input  lsu_pkg::word_t     wdata_i,
  output lsu_pkg::word_t     wdata_o,
  output lsu_pkg::strb_t     wstrb_o,
  output logic               misaligned_o
);
  import lsu_pkg::*;

  // data is replicated across lanes so the strobes alone pick the target
  always_comb
  begin
    wdata_o      = wdata_i;
    wstrb_o      = '0;
    misaligned_o = 1'b0;
    case (mem_op_i)
      MEM_SB:
      begin
        wdata_o = {4{wdata_i[7:0]}};
        wstrb_o = strb_t'(1) << byte_off_i;
      end
      MEM_SH:
      begin
        wdata_o      = {2{wdata_i[15:0]}};
        wstrb_o      = byte_off_i[1] ? 4'b1100 : 4'b0011;
        // same rule as halfword loads
        misaligned_o = byte_off_i[0];
      end
      MEM_SW:
      begin
        wdata_o      = wdata_i;
        wstrb_o      = 4'b1111;
        misaligned_o = |byte_off_i;
      end
      default:
      begin
        // loads and non-memory ops write nothing
        wdata_o      = wdata_i;
        wstrb_o      = '0;
        misaligned_o = 1'b0;
      end
    endcase
  end

endmodule

//--- verilog.f
src/lsu_pkg.sv
src/load_align.sv
src/store_align.sv
src/mem_stage.sv
sim/mem_stage_sva.sv
sim/tb_mem_stage.sv
